// ==== compile.f ====
source/voice_pkg.sv
source/sample_mem_if.sv
source/sample_ram.sv
source/fir_filter.sv
source/recorder_control.sv
source/voice_recorder.sv
testbench/voice_recorder_properties.sv
testbench/voice_recorder_tb.sv

// ==== Bender.yml ====
package:
  name: voice_recorder

sources:
  - source/voice_pkg.sv
  - source/sample_mem_if.sv
  - source/sample_ram.sv
  - source/fir_filter.sv
  - source/recorder_control.sv
  - source/voice_recorder.sv
  - target: simulation
    files:
      - testbench/voice_recorder_properties.sv
      - testbench/voice_recorder_tb.sv

// ==== testbench/voice_recorder_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// table-driven testbench for the voice recorder core
// a behavioral model tracks memory, addressing and filter history per frame
module voice_recorder_tb import voice_pkg::*; ();

   localparam int ADDR_WIDTH    = 6;
   localparam int RECORD_LIMIT  = 40;
   localparam int DEPTH         = 2 ** ADDR_WIDTH;
   localparam int FRAME_SPACING = 24;
   localparam int CHECK_DELAY   = FIR_LATENCY + 2;
   localparam int NUM_TESTS     = 9;
   localparam logic [31:0] SEED = 32'heddb7bdf;

   logic    clock;
   logic    reset;
   logic    playback;
   logic    filter_enable;
   logic    codec_valid;
   sample_t mic_sample;
   sample_t speaker_sample;

   // test table, one column per array
   string test_name     [NUM_TESTS];
   logic  test_playback [NUM_TESTS];
   logic  test_filter   [NUM_TESTS];
   int    test_frames   [NUM_TESTS];

   // reference model state
   sample_t model_mem     [DEPTH];
   sample_t model_history [NUM_TAPS];
   int      model_address;
   int      model_highest;
   int      model_phase;
   logic    model_enable;
   logic    model_playback;

   logic [31:0] rng_state;
   int          check_count = 0;
   int          error_count = 0;
   int          cycle_count = 0;
   int          cycle_limit = 0;
   int          errors_before;

   voice_recorder #(
      .ADDR_WIDTH   (ADDR_WIDTH),
      .RECORD_LIMIT (RECORD_LIMIT)
   ) uut (
      .clock          (clock),
      .reset          (reset),
      .playback       (playback),
      .filter_enable  (filter_enable),
      .codec_valid    (codec_valid),
      .mic_sample     (mic_sample),
      .speaker_sample (speaker_sample)
   );

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   // watchdog, limit set once the table is loaded
   always @(posedge clock) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("timeout: run passed %0d cycles without finishing", cycle_limit);
         $display("Something failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic set_row(input int index, input string name, input logic pb,
                          input logic fe, input int frames);
      test_name[index]     = name;
      test_playback[index] = pb;
      test_filter[index]   = fe;
      test_frames[index]   = frames;
   endtask

   task automatic check_value(input sample_t actual, input sample_t expected,
                              input string what);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("** Error at time %0t: %s, expected %0d, got %0d",
                  $time, what, expected, actual);
      end
   endtask

   // weighted sum over the history, scaled by the tap sum
   function automatic sample_t filter_model();
      int sum;
      sum = 0;
      for (int i = 0; i < NUM_TAPS; i++) begin
         sum = sum + int'(model_history[i]) * int'(FIR_TAPS[i]);
      end
      return sample_t'(sum >>> FIR_SHIFT);
   endfunction

   // mode switch clears address and phase, a new take forgets the old length
   task automatic model_set_mode(input logic mode);
      if (mode != model_playback) begin
         model_address = 0;
         model_phase   = 0;
         if (!mode) begin
            model_highest = 0;
            model_enable  = 1'b1;
         end
      end
      model_playback = mode;
   endtask

   // one frame through the model, returns the expected speaker sample
   task automatic model_frame(input sample_t mic, output sample_t expected);
      sample_t source;
      source = model_playback ? model_mem[model_address] : mic;
      for (int i = NUM_TAPS - 1; i > 0; i--) begin
         model_history[i] = model_history[i-1];
      end
      model_history[0] = source;
      expected = filter_enable ? filter_model() : source;
      if (model_phase == 0) begin
         if (model_playback) begin
            model_address = (model_address == model_highest) ? 0 : model_address + 1;
         end else if (model_enable) begin
            model_mem[model_address] = expected;
            model_highest = model_address;
            if (model_address == RECORD_LIMIT - 1) begin
               model_enable = 1'b0;
            end else begin
               model_address++;
            end
         end
      end
      model_phase = (model_phase + 1) % DECIMATION;
   endtask

   // strobe one frame, check the speaker once the result has landed
   task automatic issue_frame(input int row, input int frame_index);
      sample_t expected;
      rng_state   = xorshift(rng_state);
      mic_sample  = sample_t'(rng_state[7:0]);
      codec_valid = 1'b1;
      model_frame(mic_sample, expected);
      @(posedge clock);
      #1;
      codec_valid = 1'b0;
      repeat (CHECK_DELAY - 1) @(posedge clock);
      #1;
      check_value(speaker_sample, expected,
                  $sformatf("%s frame %0d", test_name[row], frame_index));
      repeat (FRAME_SPACING - CHECK_DELAY) @(posedge clock);
      #1;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      reset         = 1'b1;
      playback      = 1'b0;
      filter_enable = 1'b0;
      codec_valid   = 1'b0;
      mic_sample    = '0;
      rng_state     = SEED;

      model_history  = '{default: '0};
      model_address  = 0;
      model_highest  = 0;
      model_phase    = 0;
      model_enable   = 1'b1;
      model_playback = 1'b0;

      // name, playback, filter, frames
      set_row(0, "record_plain",    1'b0, 1'b0, 30);
      set_row(1, "play_plain",      1'b1, 1'b0, 36);
      set_row(2, "record_full",     1'b0, 1'b0, 150);
      set_row(3, "play_full",       1'b1, 1'b0, 126);
      set_row(4, "record_filtered", 1'b0, 1'b1, 45);
      set_row(5, "play_stored",     1'b1, 1'b0, 30);
      set_row(6, "play_filtered",   1'b1, 1'b1, 30);
      set_row(7, "record_short",    1'b0, 1'b0, 12);
      set_row(8, "play_short",      1'b1, 1'b0, 15);

      // frame time of the whole table plus slack for reset and mode waits
      for (int t = 0; t < NUM_TESTS; t++) begin
         cycle_limit = cycle_limit + test_frames[t] * FRAME_SPACING;
      end
      cycle_limit = cycle_limit + 500;

      repeat (16) @(posedge clock);
      #1;
      reset = 1'b0;
      repeat (2) @(posedge clock);
      #1;
      errors_before = error_count;
      check_value(speaker_sample, '0, "speaker after reset");
      $display("test %-16s done, %0d mismatches", "after_reset",
               error_count - errors_before);

      for (int t = 0; t < NUM_TESTS; t++) begin
         errors_before = error_count;
         playback      = test_playback[t];
         filter_enable = test_filter[t];
         model_set_mode(test_playback[t]);
         repeat (4) @(posedge clock);
         #1;
         for (int f = 0; f < test_frames[t]; f++) begin
            issue_frame(t, f);
         end
         $display("test %-16s %0d frames, %0d mismatches", test_name[t],
                  test_frames[t], error_count - errors_before);
      end

      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/voice_recorder_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the recorder controller and its filter link
module voice_recorder_properties import voice_pkg::*; #(
   parameter int ADDR_WIDTH   = 14,
   parameter int RECORD_LIMIT = 16000
) (
   input logic                  clock,
   input logic                  reset,
   input logic                  codec_valid,
   input logic                  sample_valid,
   input logic                  result_valid,
   input logic                  playback_mode,
   input logic                  write_enable,
   input logic [ADDR_WIDTH-1:0] address
);

   // high from the filter start until its result strobe
   logic in_flight;

   always_ff @(posedge clock) begin
      if (reset) begin
         in_flight <= 1'b0;
      end else if (result_valid) begin
         in_flight <= 1'b0;
      end else if (sample_valid) begin
         in_flight <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // frame handshake
   ////////////////////////////////////////////////////////////////////////////

   // no back-pressure, so a new frame must wait for the result
   frame_spacing: assert property (@(posedge clock) disable iff (reset)
      $rose(codec_valid) |-> !in_flight)
      else $error("codec_valid rose while a frame was still in the filter");

   filter_latency: assert property (@(posedge clock) disable iff (reset)
      sample_valid |-> ##FIR_LATENCY result_valid)
      else $error("filter result missing FIR_LATENCY cycles after its input");

   // and no stray results either
   result_origin: assert property (@(posedge clock) disable iff (reset)
      result_valid |-> $past(sample_valid, FIR_LATENCY))
      else $error("filter result without a matching input");

   ////////////////////////////////////////////////////////////////////////////
   // memory port
   ////////////////////////////////////////////////////////////////////////////

   // the frame behind a write picked its source one cycle before sample_valid,
   // that source must have been the microphone and not the memory
   write_in_record: assert property (@(posedge clock) disable iff (reset)
      write_enable |-> !$past(playback_mode, FIR_LATENCY + 1))
      else $error("memory write from a frame taken in playback mode");

   write_single: assert property (@(posedge clock) disable iff (reset)
      write_enable |=> !write_enable)
      else $error("memory write held for two cycles");

   address_range: assert property (@(posedge clock) disable iff (reset)
      address <= RECORD_LIMIT)
      else $error("address beyond the record limit");

endmodule

// attach to every controller instance
bind recorder_control voice_recorder_properties #(
   .ADDR_WIDTH   (ADDR_WIDTH),
   .RECORD_LIMIT (RECORD_LIMIT)
) properties (
   .clock         (clock),
   .reset         (reset),
   .codec_valid   (codec_valid),
   .sample_valid  (sample_valid),
   .result_valid  (result_valid),
   .playback_mode (playback_mode),
   .write_enable  (store),
   .address       (address)
);

`default_nettype wire

// ==== source/voice_recorder.sv ====
`timescale 1ns/1ps
`default_nettype none

// voice recorder core
// codec frames in, speaker samples out, one second of 16 kHz storage
module voice_recorder import voice_pkg::*; #(
   parameter int ADDR_WIDTH   = 14,
   parameter int RECORD_LIMIT = 16000
) (
   input  logic    clock,
   input  logic    reset,
   input  logic    playback,
   input  logic    filter_enable,
   input  logic    codec_valid,
   input  sample_t mic_sample,
   output sample_t speaker_sample
);

   // filter link
   logic    sample_valid;
   sample_t sample_in;
   logic    result_valid;
   sample_t filtered;
   sample_t passthrough;

   // memory port, controller is the only master
   sample_mem_if #(.ADDR_WIDTH(ADDR_WIDTH)) sample_mem ();

   recorder_control #(
      .ADDR_WIDTH   (ADDR_WIDTH),
      .RECORD_LIMIT (RECORD_LIMIT)
   ) control (
      .clock          (clock),
      .reset          (reset),
      .playback       (playback),
      .filter_enable  (filter_enable),
      .codec_valid    (codec_valid),
      .mic_sample     (mic_sample),
      .sample_valid   (sample_valid),
      .sample_in      (sample_in),
      .result_valid   (result_valid),
      .filtered       (filtered),
      .passthrough    (passthrough),
      .speaker_sample (speaker_sample),
      .memory         (sample_mem.controller)
   );

   fir_filter filter (
      .clock        (clock),
      .reset        (reset),
      .sample_valid (sample_valid),
      .sample_in    (sample_in),
      .result_valid (result_valid),
      .filtered     (filtered),
      .passthrough  (passthrough)
   );

   sample_ram #(.ADDR_WIDTH(ADDR_WIDTH)) ram (
      .clock  (clock),
      .memory (sample_mem.memory)
   );

endmodule

`default_nettype wire

// ==== source/recorder_control.sv ====
`timescale 1ns/1ps
`default_nettype none

// record / playback controller
// detects codec frames, feeds the filter, keeps every third result in record
// mode and loops over the stored take in playback mode
module recorder_control import voice_pkg::*; #(
   parameter int ADDR_WIDTH   = 14,
   parameter int RECORD_LIMIT = 16000
) (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 playback,
   input  logic                 filter_enable,
   input  logic                 codec_valid,
   input  sample_t              mic_sample,
   output logic                 sample_valid,
   output sample_t              sample_in,
   input  logic                 result_valid,
   input  sample_t              filtered,
   input  sample_t              passthrough,
   output sample_t              speaker_sample,
   sample_mem_if.controller     memory
);

   localparam int PHASE_WIDTH = $clog2(DECIMATION);
   localparam logic [PHASE_WIDTH-1:0] PHASE_LAST = PHASE_WIDTH'(DECIMATION - 1);
   localparam logic [ADDR_WIDTH-1:0]  LAST_ADDRESS = ADDR_WIDTH'(RECORD_LIMIT - 1);

   logic                   codec_valid_prev;
   logic                   frame;
   logic                   playback_mode;
   logic                   mode_change;
   logic [ADDR_WIDTH-1:0]  address;
   logic [ADDR_WIDTH-1:0]  highest_address;
   logic [PHASE_WIDTH-1:0] phase;
   logic                   record_enable;
   logic                   store;
   sample_t                selected;

   ////////////////////////////////////////////////////////////////////////////
   // frame and mode detection
   ////////////////////////////////////////////////////////////////////////////

   // rising edge of the codec strobe
   assign frame = codec_valid & ~codec_valid_prev;

   // playback differs from the mode register for one cycle after a switch
   assign mode_change = playback != playback_mode;

   // output path, filter switch applies in both modes
   assign selected = filter_enable ? filtered : passthrough;

   // keep only phase zero results, and stop once the take is full
   assign store = result_valid & ~mode_change & ~playback_mode
                  & (phase == '0) & record_enable;

   // memory port
   assign memory.address      = address;
   assign memory.write_enable = store;
   assign memory.write_data   = selected;

   // source sample into the filter, registered with the frame strobe
   // memory word is stable here, address only moves on result_valid
   always_ff @(posedge clock) begin
      if (frame) begin
         sample_in <= playback_mode ? memory.read_data : mic_sample;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // addressing, decimation and speaker register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         codec_valid_prev <= 1'b0;
         sample_valid     <= 1'b0;
         playback_mode    <= 1'b0;
         address          <= '0;
         highest_address  <= '0;
         phase            <= '0;
         record_enable    <= 1'b1;
         speaker_sample   <= '0;
      end else begin
         codec_valid_prev <= codec_valid;
         sample_valid     <= frame;
         playback_mode    <= playback;

         if (mode_change) begin
            // any switch restarts at the top of memory
            address <= '0;
            phase   <= '0;
            // new take, forget the old length
            if (!playback) begin
               highest_address <= '0;
               record_enable   <= 1'b1;
            end
         end else if (result_valid) begin
            speaker_sample <= selected;
            phase          <= (phase == PHASE_LAST) ? '0 : phase + 1'b1;

            if (phase == '0) begin
               if (playback_mode) begin
                  // loop over the stored take
                  if (address == highest_address) begin
                     address <= '0;
                  end else begin
                     address <= address + 1'b1;
                  end
               end else if (record_enable) begin
                  // the write itself goes out through store this cycle
                  highest_address <= address;
                  if (address == LAST_ADDRESS) begin
                     record_enable <= 1'b0;
                  end else begin
                     address <= address + 1'b1;
                  end
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/fir_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

// sequential low-pass fir over the frame stream
// one multiply-accumulate per clock, result FIR_LATENCY cycles after sample_valid
module fir_filter import voice_pkg::*; (
   input  logic    clock,
   input  logic    reset,
   input  logic    sample_valid,
   input  sample_t sample_in,
   output logic    result_valid,
   output sample_t filtered,
   output sample_t passthrough
);

   localparam int INDEX_WIDTH   = $clog2(NUM_TAPS);
   localparam int PRODUCT_WIDTH = SAMPLE_WIDTH + COEFF_WIDTH + 1;
   localparam logic [INDEX_WIDTH-1:0] LAST_TAP = INDEX_WIDTH'(NUM_TAPS - 1);

   // history[0] is the newest sample
   sample_t history [NUM_TAPS];

   logic [INDEX_WIDTH-1:0]       tap_index;
   logic                         mac_active;
   logic                         scale_pending;
   logic signed [COEFF_WIDTH:0]  coeff;
   logic signed [PRODUCT_WIDTH-1:0] product;
   logic signed [ACC_WIDTH-1:0]  acc;

   // taps are non-negative, extend with a zero sign bit
   assign coeff   = {1'b0, FIR_TAPS[tap_index]};
   assign product = history[tap_index] * coeff;

   ////////////////////////////////////////////////////////////////////////////
   // sequencing and history
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         history       <= '{default: '0};
         tap_index     <= '0;
         mac_active    <= 1'b0;
         scale_pending <= 1'b0;
         result_valid  <= 1'b0;
      end else begin
         // strobe follows the scale cycle
         result_valid  <= scale_pending;
         scale_pending <= 1'b0;
         if (sample_valid) begin
            // shift in the new sample, restart the tap walk
            history[0] <= sample_in;
            for (int i = 1; i < NUM_TAPS; i++) begin
               history[i] <= history[i-1];
            end
            tap_index  <= '0;
            mac_active <= 1'b1;
         end else if (mac_active) begin
            tap_index <= tap_index + 1'b1;
            if (tap_index == LAST_TAP) begin
               mac_active    <= 1'b0;
               scale_pending <= 1'b1;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // datapath
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (sample_valid) begin
         acc         <= '0;
         passthrough <= sample_in;
      end else if (mac_active) begin
         acc <= acc + ACC_WIDTH'(product);
      end
      // divide by 64, taps sum keeps this in range
      if (scale_pending) begin
         filtered <= acc[FIR_SHIFT +: SAMPLE_WIDTH];
      end
   end

endmodule

`default_nettype wire

// ==== source/sample_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

// single-port synchronous sample memory
// write on the clock edge, read registered (old data on a same-address write)
module sample_ram import voice_pkg::*; #(
   parameter int ADDR_WIDTH = 14
) (
   input  logic                clock,
   sample_mem_if.memory        memory
);

   localparam int DEPTH = 2 ** ADDR_WIDTH;

   // sample storage, contents undefined until recorded
   sample_t storage [DEPTH];

   // write port
   always_ff @(posedge clock) begin
      if (memory.write_enable) begin
         storage[memory.address] <= memory.write_data;
      end
   end

   // registered read port
   always_ff @(posedge clock) begin
      memory.read_data <= storage[memory.address];
   end

endmodule

`default_nettype wire

// ==== source/sample_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// single port to the sample memory
// read_data is registered and holds the word at last cycle's address
interface sample_mem_if import voice_pkg::*; #(
   parameter int ADDR_WIDTH = 14
) ();

   logic [ADDR_WIDTH-1:0] address;
   logic                  write_enable;
   sample_t               write_data;
   sample_t               read_data;

   // recorder side, owns address and write strobe
   modport controller (
      output address, write_enable, write_data,
      input  read_data
   );

   // storage side
   modport memory (
      input  address, write_enable, write_data,
      output read_data
   );

endinterface

`default_nettype wire

// ==== source/voice_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// shared sample format and filter constants for the voice recorder
////////////////////////////////////////////////////////////////////////////

package voice_pkg;

   // pcm sample format, two's complement
   localparam int SAMPLE_WIDTH = 8;
   typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

   // low-pass fir, triangular window
   localparam int NUM_TAPS    = 15;
   localparam int COEFF_WIDTH = 8;

   // taps are symmetric and sum to 64
   localparam logic [COEFF_WIDTH-1:0] FIR_TAPS [NUM_TAPS] = '{
      8'd1, 8'd2, 8'd3, 8'd4, 8'd5, 8'd6, 8'd7, 8'd8,
      8'd7, 8'd6, 8'd5, 8'd4, 8'd3, 8'd2, 8'd1
   };

   // divide by the tap sum (64), so the result stays in sample range
   localparam int FIR_SHIFT = 6;

   // worst case |sum| is 128 * 64, well inside 20 bits
   localparam int ACC_WIDTH = 20;

   // one cycle to load the history, one per tap, one to scale
   localparam int FIR_LATENCY = NUM_TAPS + 2;

   // 48 kHz codec frames down to 16 kHz stored samples
   localparam int DECIMATION = 3;

endpackage

`default_nettype wire
